// File: hw/fetch_config.svh
// fetch unit configuration
// reset vector, AXI id width and the idle instruction word

`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// byte address, bit 0 must be zero
`define FETCH_RESET_PC 32'h0000_0100

`define FETCH_AXI_ID_W 4

`define FETCH_NOP 32'h0000_0013  // addi x0, x0, 0

`endif

// File: hw/fetch_pkg.sv
// fetch unit types
// parcel view union for jump predecode and the memory controller FSM states

package fetch_pkg;

  // 32-bit J-type view, JAL lives here
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_view_t;

  // compressed CJ view, C.J and C.JAL
  typedef struct packed {
    logic [15:0] upper;   // ignored for 16-bit parcels
    logic [2:0]  funct3;
    logic [10:0] jimm;    // inst[12:2]
    logic [1:0]  op;
  } cj_view_t;

  typedef union packed {
    j_view_t  j;
    cj_view_t cj;
  } parcel_t;

  typedef enum logic [1:0] {
    mem_req,   // waiting for the AR handshake
    mem_wait,  // response outstanding
    mem_hold   // line buffered for the sequencer
  } mem_state_e;

endpackage

// File: hw/line_fetch_if.sv
// line handoff between the AXI read engine and the instruction sequencer

`timescale 1ns/1ps

interface line_fetch_if;
  logic        redirect;     // drop buffer, refetch at redirect_pc
  logic [31:1] redirect_pc;
  logic        line_valid;
  logic [63:0] line;
  logic [31:3] line_addr;
  logic        line_take;    // sequencer is done with this line

  modport mem (
    input  redirect, redirect_pc, line_take,
    output line_valid, line, line_addr
  );

  modport seq (
    output redirect, redirect_pc, line_take,
    input  line_valid, line, line_addr
  );
endinterface

// File: hw/jump_predecode.sv
// direct jump predecoder for one instruction parcel
// flags JAL, C.J and C.JAL and builds the sign-extended pc offset

`timescale 1ns/1ps

module jump_predecode import fetch_pkg::*; (
  input  parcel_t     parcel,
  output logic        is_comp,
  output logic        is_jump,
  output logic [31:1] offset
);

  logic        jal;
  logic        cj;
  logic [31:1] j_offset;
  logic [31:1] cj_offset;

  assign is_comp = (parcel.cj.op != 2'b11);

  assign jal = !is_comp && (parcel.j.opcode == 7'b110_1111);

  // C.J is funct3 101, C.JAL is 001 on RV32
  assign cj = (parcel.cj.op == 2'b01) &&
              ((parcel.cj.funct3 == 3'b101) || (parcel.cj.funct3 == 3'b001));

  assign is_jump = jal || cj;

  assign j_offset = {
    {11{parcel.j.imm20}},
    parcel.j.imm20,
    parcel.j.imm19_12,
    parcel.j.imm11,
    parcel.j.imm10_1
  };

  // offset[11|4|9:8|10|6|7|3:1|5] scrambled into inst[12:2]
  assign cj_offset = {
    {20{parcel.cj.jimm[10]}},
    parcel.cj.jimm[10],
    parcel.cj.jimm[6],
    parcel.cj.jimm[8:7],
    parcel.cj.jimm[4],
    parcel.cj.jimm[5],
    parcel.cj.jimm[0],
    parcel.cj.jimm[9],
    parcel.cj.jimm[3:1]
  };

  assign offset = is_comp ? cj_offset : j_offset;

endmodule

// File: hw/fetch_mem_ctrl.sv
// instruction fetch AXI read engine
// one 64-bit line per request, one line buffer, stale responses dropped

`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_mem_ctrl import fetch_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  line_fetch_if.mem                   lf,
  output logic [`FETCH_AXI_ID_W-1:0] arid,
  output logic [31:0]                 araddr,
  output logic                        arvalid,
  output logic                        rready,
  input  logic                        arready,
  input  logic [`FETCH_AXI_ID_W-1:0] rid,
  input  logic [63:0]                 rdata,
  input  logic                        rlast,
  input  logic                        rvalid
);

  localparam logic [31:0] reset_pc = `FETCH_RESET_PC;

  mem_state_e  state;
  logic [31:3] next_addr;   // line to fetch on the next request
  logic [31:3] ar_addr;
  logic [31:3] issue_addr;
  logic        drop;        // outstanding response is stale
  logic        r_done;
  logic [63:0] line_q;
  logic [31:3] line_addr_q;

  // a redirect in the issue cycle goes straight onto the bus
  assign issue_addr = lf.redirect ? lf.redirect_pc[31:3] : next_addr;
  assign r_done     = rvalid && rready && rlast;

  assign araddr        = {ar_addr, 3'b000};
  assign rready        = (state == mem_wait);
  assign lf.line_valid = (state == mem_hold);
  assign lf.line       = line_q;
  assign lf.line_addr  = line_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= mem_req;
      arvalid   <= 1'b0;
      arid      <= '0;
      drop      <= 1'b0;
      next_addr <= reset_pc[31:3];
    end else begin
      unique case (state)
        mem_req: begin
          if (!arvalid) begin
            arvalid <= 1'b1;
            arid    <= arid + 1'b1;  // fresh tag per request
          end else if (arready) begin
            arvalid <= 1'b0;
            state   <= mem_wait;
          end
        end
        mem_wait: begin
          if (r_done) begin
            state <= (drop || lf.redirect) ? mem_req : mem_hold;
          end
        end
        mem_hold: begin
          if (lf.redirect || lf.line_take) begin
            state <= mem_req;
          end
        end
        default: state <= mem_req;
      endcase

      // redirect wins over line_take
      if (lf.redirect) begin
        next_addr <= lf.redirect_pc[31:3];
      end else if ((state == mem_hold) && lf.line_take) begin
        next_addr <= line_addr_q + 1'b1;
      end

      if ((state == mem_wait) && r_done) begin
        drop <= 1'b0;
      end else if (lf.redirect && (arvalid || (state == mem_wait))) begin
        drop <= 1'b1;  // request already committed on the bus
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((state == mem_req) && !arvalid) begin
      ar_addr <= issue_addr;
    end
    if ((state == mem_wait) && r_done) begin
      line_q      <= rdata;
      line_addr_q <= ar_addr;
    end
  end

  ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr));

  // single outstanding read, response must carry its tag
  r_expected: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid |-> (state == mem_wait) && (rid == arid));

endmodule

// File: hw/fetch_sequencer.sv
// instruction sequencer
// walks a fetched line in program order, one instruction per cycle to decode

`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_sequencer import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        pc_update,
  input  logic [31:1] pc_in,
  line_fetch_if.seq   lf,
  output logic [31:0] instr_d0,
  output logic [31:1] pc_d0,
  output logic        comp_d0,
  output logic        instr_valid_d0,
  output logic        illegal_d0
);

  localparam logic [31:0] reset_pc = `FETCH_RESET_PC;

  logic [31:1] pc;
  logic        halted;      // set after a line-crossing 32-bit parcel
  parcel_t     parcel [4];
  logic [3:0]  is_comp;
  logic [3:0]  is_jump;
  logic [31:1] offset [4];
  logic [1:0]  sel;
  parcel_t     sel_parcel;
  logic [31:0] sel_instr;
  logic        sel_comp;
  logic        line_hit;
  logic        step;
  logic        illegal;
  logic        take_jump;
  logic [31:1] next_pc;
  logic [31:1] jump_pc;

  // parcel k starts at halfword k, the last one has no upper half
  assign parcel[0] = lf.line[31:0];
  assign parcel[1] = lf.line[47:16];
  assign parcel[2] = lf.line[63:32];
  assign parcel[3] = {16'h0000, lf.line[63:48]};

  for (genvar i = 0; i < 4; i++) begin : g_predec
    jump_predecode u_predec (
      .parcel  (parcel[i]),
      .is_comp (is_comp[i]),
      .is_jump (is_jump[i]),
      .offset  (offset[i])
    );
  end

  assign sel        = pc[2:1];
  assign sel_parcel = parcel[sel];
  assign sel_comp   = is_comp[sel];
  assign sel_instr  = sel_comp ? {16'h0000, sel_parcel[15:0]} : sel_parcel;

  assign line_hit  = lf.line_valid && (lf.line_addr == pc[31:3]);
  assign step      = line_hit && !halted && !pc_update;
  assign illegal   = !sel_comp && (sel == 2'd3);
  assign take_jump = step && is_jump[sel] && !illegal;

  assign next_pc = pc + (sel_comp ? 31'd1 : 31'd2);
  assign jump_pc = pc + offset[sel];

  assign lf.redirect    = pc_update || take_jump;
  assign lf.redirect_pc = pc_update ? pc_in : jump_pc;
  assign lf.line_take   = step && !take_jump && !illegal && (next_pc[31:3] != pc[31:3]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc     <= reset_pc[31:1];
      halted <= 1'b0;
    end else if (pc_update) begin
      pc     <= pc_in;
      halted <= 1'b0;
    end else if (step) begin
      if (illegal) begin
        halted <= 1'b1;  // wait for pc_update
      end else if (take_jump) begin
        pc <= jump_pc;
      end else begin
        pc <= next_pc;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_d0 <= 1'b0;
      illegal_d0     <= 1'b0;
      comp_d0        <= 1'b0;
      instr_d0       <= `FETCH_NOP;
    end else begin
      instr_valid_d0 <= step;
      illegal_d0     <= step && illegal;
      comp_d0        <= step && sel_comp;
      instr_d0       <= step ? sel_instr : `FETCH_NOP;
    end
  end

  always_ff @(posedge clk) begin
    if (step) pc_d0 <= pc;
  end

  flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    pc_update |=> !instr_valid_d0);

  take_needs_line: assert property (@(posedge clk) disable iff (!rst_n)
    lf.line_take |-> lf.line_valid);

endmodule

// File: hw/fetch_unit.sv
// instruction fetch unit top
// AXI4 read master plus line sequencer, constant AR attributes tied here

`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_unit (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        pc_update,
  input  logic [31:1]                 pc_in,
  output logic [31:0]                 instr_d0,
  output logic [31:1]                 pc_d0,
  output logic                        comp_d0,
  output logic                        instr_valid_d0,
  output logic                        illegal_d0,
  // AR channel
  output logic [`FETCH_AXI_ID_W-1:0] axi_arid,
  output logic [31:0]                 axi_araddr,
  output logic [7:0]                  axi_arlen,
  output logic [2:0]                  axi_arsize,
  output logic [1:0]                  axi_arburst,
  output logic [3:0]                  axi_arcache,
  output logic [2:0]                  axi_arprot,
  output logic                        axi_arvalid,
  input  logic                        axi_arready,
  // R channel, rresp is not checked
  input  logic [`FETCH_AXI_ID_W-1:0] axi_rid,
  input  logic [63:0]                 axi_rdata,
  input  logic [1:0]                  axi_rresp,
  input  logic                        axi_rlast,
  input  logic                        axi_rvalid,
  output logic                        axi_rready
);

  line_fetch_if lf_if ();

  assign axi_arlen   = 8'd0;     // single beat
  assign axi_arsize  = 3'd3;     // 8 bytes
  assign axi_arburst = 2'b01;    // INCR
  assign axi_arcache = 4'b0010;  // normal non-cacheable
  assign axi_arprot  = 3'b100;   // instruction, secure, unprivileged

  fetch_mem_ctrl u_mem_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .lf      (lf_if.mem),
    .arid    (axi_arid),
    .araddr  (axi_araddr),
    .arvalid (axi_arvalid),
    .rready  (axi_rready),
    .arready (axi_arready),
    .rid     (axi_rid),
    .rdata   (axi_rdata),
    .rlast   (axi_rlast),
    .rvalid  (axi_rvalid)
  );

  fetch_sequencer u_sequencer (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_update      (pc_update),
    .pc_in          (pc_in),
    .lf             (lf_if.seq),
    .instr_d0       (instr_d0),
    .pc_d0          (pc_d0),
    .comp_d0        (comp_d0),
    .instr_valid_d0 (instr_valid_d0),
    .illegal_d0     (illegal_d0)
  );

endmodule

// File: verification/axi_mem_model.sv
// AXI4 read slave for the fetch unit testbench
// halfword memory image, random AR and R delays of 0 to 4 cycles, single-beat reads

`timescale 1ns/1ps
`include "fetch_config.svh"

module axi_mem_model #(
  parameter logic [31:0] seed = 32'hab96
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`FETCH_AXI_ID_W-1:0] arid,
  input  logic [31:0]                 araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [`FETCH_AXI_ID_W-1:0] rid,
  output logic [63:0]                 rdata,
  output logic [1:0]                  rresp,
  output logic                        rlast,
  output logic                        rvalid,
  input  logic                        rready
);

  logic [15:0] mem [0:2047];  // 4 KB, addresses alias above that

  function automatic logic [63:0] read_line(input logic [31:0] addr);
    logic [10:0] base;
    base = {addr[11:3], 2'b00};
    return {mem[base + 11'd3], mem[base + 11'd2], mem[base + 11'd1], mem[base]};
  endfunction

  // advance n cycles, landing just after the rising edge
  task automatic skip_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    logic [`FETCH_AXI_ID_W-1:0] id;
    logic [31:0]                addr;
    void'($urandom(seed));
    arready = 1'b0;
    rvalid  = 1'b0;
    rlast   = 1'b0;
    rid     = '0;
    rdata   = '0;
    rresp   = 2'b00;
    forever begin
      @(posedge clk);
      #1;
      if (rst_n && arvalid) begin
        skip_cycles($urandom_range(4));
        id      = arid;
        addr    = araddr;
        arready = 1'b1;
        skip_cycles(1);
        arready = 1'b0;
        skip_cycles($urandom_range(4));
        rid    = id;
        rdata  = read_line(addr);
        rlast  = 1'b1;
        rvalid = 1'b1;
        skip_cycles(1);  // rready is high while the read is outstanding
        rvalid = 1'b0;
        rlast  = 1'b0;
      end
    end
  end

endmodule

// File: verification/fetch_unit_tb.sv
// fetch unit testbench
// program images in the AXI memory model, reference pc model and bus checks

`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_unit_tb;

  logic                        clk;
  logic                        rst_n;
  logic                        pc_update;
  logic [31:1]                 pc_in;
  logic [31:0]                 instr_d0;
  logic [31:1]                 pc_d0;
  logic                        comp_d0;
  logic                        instr_valid_d0;
  logic                        illegal_d0;
  logic [`FETCH_AXI_ID_W-1:0] axi_arid;
  logic [31:0]                 axi_araddr;
  logic [7:0]                  axi_arlen;
  logic [2:0]                  axi_arsize;
  logic [1:0]                  axi_arburst;
  logic [3:0]                  axi_arcache;
  logic [2:0]                  axi_arprot;
  logic                        axi_arvalid;
  logic                        axi_arready;
  logic [`FETCH_AXI_ID_W-1:0] axi_rid;
  logic [63:0]                 axi_rdata;
  logic [1:0]                  axi_rresp;
  logic                        axi_rlast;
  logic                        axi_rvalid;
  logic                        axi_rready;

  int errors;
  int tests_run;
  int tests_bad;

  logic [31:0] exp_pc;     // byte address of the next expected instruction
  logic        exp_halt;
  logic [15:0] exp_lo;
  logic [15:0] exp_hi;
  logic        exp_comp;
  logic        exp_illegal;
  logic [31:0] exp_instr;
  logic        outstanding;

  fetch_unit fetch_unit_inst (.*);

  axi_mem_model #(.seed(32'hab96)) mem_model (
    .clk     (clk),
    .rst_n   (rst_n),
    .arid    (axi_arid),
    .araddr  (axi_araddr),
    .arvalid (axi_arvalid),
    .arready (axi_arready),
    .rid     (axi_rid),
    .rdata   (axi_rdata),
    .rresp   (axi_rresp),
    .rlast   (axi_rlast),
    .rvalid  (axi_rvalid),
    .rready  (axi_rready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  assign exp_lo      = mem_model.mem[exp_pc[11:1]];
  assign exp_hi      = mem_model.mem[exp_pc[11:1] + 11'd1];
  assign exp_comp    = (exp_lo[1:0] != 2'b11);
  assign exp_illegal = !exp_comp && (exp_pc[2:1] == 2'd3);
  // upper half of a line-crossing instruction is never fetched
  assign exp_instr   = (exp_comp || exp_illegal) ? {16'h0000, exp_lo} : {exp_hi, exp_lo};

  // next pc from the RISC-V encodings of JAL, C.J and C.JAL
  function automatic logic [31:0] ref_next_pc(input logic [31:0] pc, input logic [31:0] instr);
    logic [31:0] imm;
    logic [31:0] next;
    if (instr[1:0] != 2'b11) begin
      if ((instr[1:0] == 2'b01) && ((instr[15:13] == 3'b101) || (instr[15:13] == 3'b001))) begin
        imm  = {{21{instr[12]}}, instr[8], instr[10:9], instr[6], instr[7], instr[2],
                instr[11], instr[5:3], 1'b0};
        next = pc + imm;
      end else begin
        next = pc + 32'd2;
      end
    end else if (instr[6:0] == 7'b110_1111) begin
      imm  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      next = pc + imm;
    end else begin
      next = pc + 32'd4;
    end
    return next;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_pc      <= `FETCH_RESET_PC;
      exp_halt    <= 1'b0;
      outstanding <= 1'b0;
    end else begin
      if (pc_update) begin
        exp_pc   <= {pc_in, 1'b0};
        exp_halt <= 1'b0;
      end else if (instr_valid_d0) begin
        if (exp_illegal) exp_halt <= 1'b1;
        else exp_pc <= ref_next_pc(exp_pc, exp_instr);
      end
      if (axi_arvalid && axi_arready) outstanding <= 1'b1;
      else if (axi_rvalid && axi_rready && axi_rlast) outstanding <= 1'b0;
    end
  end

  check_instr: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_d0 && !exp_halt |-> pc_d0 == exp_pc[31:1] && instr_d0 == exp_instr &&
      comp_d0 == exp_comp && illegal_d0 == exp_illegal)
    else begin
      errors++;
      $display("FAILED %0t: pc %h instr %h comp %b illegal %b, expected pc %h instr %h",
               $time, {pc_d0, 1'b0}, instr_d0, comp_d0, illegal_d0, exp_pc, exp_instr);
    end

  check_halt: assert property (@(posedge clk) disable iff (!rst_n)
    exp_halt |-> !instr_valid_d0)
    else begin
      errors++;
      $display("valid instruction at %0t while fetch should be halted", $time);
    end

  check_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !instr_valid_d0 |-> instr_d0 == `FETCH_NOP && !illegal_d0)
    else begin
      errors++;
      $display("FAILED %0t: idle output instr %h illegal %b", $time, instr_d0, illegal_d0);
    end

  check_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    pc_update |=> !instr_valid_d0)
    else begin
      errors++;
      $display("valid instruction at %0t right after pc_update", $time);
    end

  // INCR single beat, arprot[2] marks an instruction access
  check_ar_attr: assert property (@(posedge clk) disable iff (!rst_n)
    axi_arvalid |-> axi_araddr[2:0] == 3'd0 && axi_arlen == 8'd0 && axi_arsize == 3'd3 &&
      axi_arburst == 2'b01 && axi_arprot[2])
    else begin
      errors++;
      $display("FAILED %0t: araddr %h arlen %0d arsize %0d arburst %b arprot %b", $time,
               axi_araddr, axi_arlen, axi_arsize, axi_arburst, axi_arprot);
    end

  check_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr) && $stable(axi_arid) &&
      $stable(axi_arcache) && $stable(axi_arprot))
    else begin
      errors++;
      $display("AR request at %0t dropped or changed before its handshake", $time);
    end

  check_single: assert property (@(posedge clk) disable iff (!rst_n)
    axi_arvalid |-> !outstanding)
    else begin
      errors++;
      $display("read requested at %0t while one is outstanding", $time);
    end

  check_r: assert property (@(posedge clk) disable iff (!rst_n)
    axi_rvalid |-> outstanding && axi_rready)
    else begin
      errors++;
      $display("read response at %0t without a request or without rready", $time);
    end

  task automatic set_half(input logic [31:0] addr, input logic [15:0] half);
    mem_model.mem[addr[11:1]] = half;
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] word);
    set_half(addr, word[15:0]);
    set_half(addr + 32'd2, word[31:16]);
  endtask

  task automatic load_images();
    int i;
    // c.addi filler, never a jump, immediate follows the address
    for (i = 0; i < 2048; i++) begin
      mem_model.mem[i] = {3'b000, i[10:0], 2'b01};
    end
    set_half(32'h100, 16'h0505);          // straight line from reset
    write_word(32'h102, 32'h0050_0593);
    set_half(32'h106, 16'h4581);
    write_word(32'h108, 32'h00b5_0633);
    write_word(32'h10c, 32'h00c0_0693);
    set_half(32'h110, 16'h8532);
    set_half(32'h112, 16'h0001);
    set_half(32'h200, 16'h0001);
    write_word(32'h202, 32'h0400_006f);   // jal x0, +0x40
    set_half(32'h242, 16'h0505);
    write_word(32'h244, 32'h0050_0593);
    set_half(32'h248, 16'hbfed);          // c.j -6
    set_half(32'h500, 16'h0001);
    set_half(32'h502, 16'h0505);
    set_half(32'h504, 16'h4581);
    write_word(32'h506, 32'h0050_0593);   // crosses into the next line
  endtask

  task automatic await_pc(input logic [31:0] target, input int hits, input int limit);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    while ((seen < hits) && (cycles < limit)) begin
      @(posedge clk);
      #1;
      cycles++;
      if (instr_valid_d0 && (pc_d0 == target[31:1])) seen++;
    end
    if (seen < hits) begin
      errors++;
      $display("timed out after %0d cycles waiting for pc %h", limit, target);
    end
  endtask

  task automatic find_read_in_flight(input int limit);
    int cycles;
    cycles = 0;
    while (!axi_rready && (cycles < limit)) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!axi_rready) begin
      errors++;
      $display("no read in flight within %0d cycles", limit);
    end
  endtask

  task automatic pulse_pc_update(input logic [31:0] target);
    pc_update = 1'b1;
    pc_in     = target[31:1];
    @(posedge clk);
    #1;
    pc_update = 1'b0;
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
    end
  endtask

  initial begin
    int mark;
    int k;
    errors    = 0;
    tests_run = 0;
    tests_bad = 0;
    rst_n     = 1'b0;
    pc_update = 1'b0;
    pc_in     = '0;
    load_images();
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    mark = errors;
    await_pc(32'h112, 1, 200);
    report_test("straight line", mark);

    mark = errors;
    pulse_pc_update(32'h200);
    await_pc(32'h248, 3, 300);  // three turns of the c.j loop
    report_test("jal and c.j loop", mark);

    mark = errors;
    for (k = 0; k < 4; k++) begin
      find_read_in_flight(50);
      pulse_pc_update(32'h300 + k * 32'h26);
      await_pc(32'h300 + k * 32'h26, 1, 200);
    end
    report_test("pc_update during reads", mark);

    mark = errors;
    pulse_pc_update(32'h500);
    await_pc(32'h506, 1, 200);
    for (k = 0; k < 20; k++) begin
      @(posedge clk);
      #1;
    end
    pulse_pc_update(32'h600);
    await_pc(32'h600, 1, 200);
    report_test("line-crossing instruction", mark);

    mark = errors;
    pulse_pc_update(32'h700);
    await_pc(32'h740, 1, 400);
    report_test("axi protocol", mark);

    $display("tests run %0d, tests with errors %0d, check errors %0d",
             tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: fetch_unit.f
+incdir+hw
hw/fetch_pkg.sv
hw/line_fetch_if.sv
hw/jump_predecode.sv
hw/fetch_mem_ctrl.sv
hw/fetch_sequencer.sv
hw/fetch_unit.sv
verification/axi_mem_model.sv
verification/fetch_unit_tb.sv

// File: Makefile
SRCS := $(wildcard hw/*.sv hw/*.svh verification/*.sv)

.PHONY: run clean

run: obj_dir/Vfetch_unit_tb
	./obj_dir/Vfetch_unit_tb > sim.log 2>&1 || (cat sim.log; false)
	@cat sim.log
	@! grep -q "Test failures found" sim.log

obj_dir/Vfetch_unit_tb: $(SRCS) fetch_unit.f
	verilator --binary --timing --assert -Wno-fatal --top-module fetch_unit_tb -f fetch_unit.f

clean:
	rm -rf obj_dir sim.log
